//--- hdl/mem_unit_pkg.sv
package mem_unit_pkg;

    // Word-addressed bus widths
    localparam int ADDR_WIDTH   = 30;
    localparam int DATA_WIDTH   = 32;
    localparam int BYTEEN_WIDTH = DATA_WIDTH / 8;

    // Bit 0 of the data port tag selects shared memory
    localparam int CORE_TAG_WIDTH = 4;
    localparam int SMEM_TAG_WIDTH = CORE_TAG_WIDTH - 1;

    // Bit 0 of the external tag is the source (0 fetch, 1 data)
    localparam int MEM_TAG_WIDTH = SMEM_TAG_WIDTH + 1;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]     addr;
        logic                      rw;
        logic [BYTEEN_WIDTH-1:0]   byteen;
        logic [DATA_WIDTH-1:0]     data;
        logic [SMEM_TAG_WIDTH-1:0] tag;
    } data_req_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]    addr;
        logic                     rw;
        logic [BYTEEN_WIDTH-1:0]  byteen;
        logic [DATA_WIDTH-1:0]    data;
        logic [MEM_TAG_WIDTH-1:0] tag;
    } mem_req_t;

endpackage

//--- hdl/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic reset,
    input  logic valid_in,
    input  T     data_in,
    output logic ready_in,
    output logic valid_out,
    output T     data_out,
    input  logic ready_out
);

    logic valid_main;
    logic valid_skid;
    T     data_main;
    T     data_skid;
    logic advance;

    // Output register free or being drained
    assign advance = ready_out || !valid_main;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_main <= 1'b0;
            valid_skid <= 1'b0;
        end else if (advance) begin
            valid_main <= valid_skid || valid_in;
            valid_skid <= 1'b0;
        end else if (valid_in && ready_in) begin
            valid_skid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            data_main <= valid_skid ? data_skid : data_in;
        end else if (valid_in && ready_in) begin
            data_skid <= data_in;
        end
    end

    // No combinational path from ready_out to ready_in
    assign ready_in  = !valid_skid;
    assign valid_out = valid_main;
    assign data_out  = data_main;

endmodule

//--- hdl/smem_arb.sv
`timescale 1ns/1ps

module smem_arb import mem_unit_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      data_req_valid,
    input  logic                      data_req_rw,
    input  logic [BYTEEN_WIDTH-1:0]   data_req_byteen,
    input  logic [ADDR_WIDTH-1:0]     data_req_addr,
    input  logic [DATA_WIDTH-1:0]     data_req_data,
    input  logic [CORE_TAG_WIDTH-1:0] data_req_tag,
    output logic                      data_req_ready,

    output logic                      data_rsp_valid,
    output logic [DATA_WIDTH-1:0]     data_rsp_data,
    output logic [CORE_TAG_WIDTH-1:0] data_rsp_tag,
    input  logic                      data_rsp_ready,

    output logic                      smem_req_valid,
    output logic                      smem_req_rw,
    output logic [BYTEEN_WIDTH-1:0]   smem_req_byteen,
    output logic [ADDR_WIDTH-1:0]     smem_req_addr,
    output logic [DATA_WIDTH-1:0]     smem_req_data,
    output logic [SMEM_TAG_WIDTH-1:0] smem_req_tag,
    input  logic                      smem_req_ready,

    input  logic                      smem_rsp_valid,
    input  logic [DATA_WIDTH-1:0]     smem_rsp_data,
    input  logic [SMEM_TAG_WIDTH-1:0] smem_rsp_tag,
    output logic                      smem_rsp_ready,

    output logic                      dmem_req_valid,
    output logic                      dmem_req_rw,
    output logic [BYTEEN_WIDTH-1:0]   dmem_req_byteen,
    output logic [ADDR_WIDTH-1:0]     dmem_req_addr,
    output logic [DATA_WIDTH-1:0]     dmem_req_data,
    output logic [SMEM_TAG_WIDTH-1:0] dmem_req_tag,
    input  logic                      dmem_req_ready,

    input  logic                      dmem_rsp_valid,
    input  logic [DATA_WIDTH-1:0]     dmem_rsp_data,
    input  logic [SMEM_TAG_WIDTH-1:0] dmem_rsp_tag,
    output logic                      dmem_rsp_ready
);

    typedef struct packed {
        data_req_t req;
        logic      smem;
    } req_entry_t;

    req_entry_t entry_in;
    req_entry_t entry_out;
    logic       buf_valid;
    logic       buf_ready;

    always_comb begin
        entry_in.req.addr   = data_req_addr;
        entry_in.req.rw     = data_req_rw;
        entry_in.req.byteen = data_req_byteen;
        entry_in.req.data   = data_req_data;
        entry_in.req.tag    = data_req_tag[CORE_TAG_WIDTH-1:1];
        entry_in.smem       = data_req_tag[0];
    end

    skid_buffer #(
        .T (req_entry_t)
    ) req_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (data_req_valid),
        .data_in   (entry_in),
        .ready_in  (data_req_ready),
        .valid_out (buf_valid),
        .data_out  (entry_out),
        .ready_out (buf_ready)
    );

    // Steer by the stored flag
    assign smem_req_valid  = buf_valid && entry_out.smem;
    assign dmem_req_valid  = buf_valid && !entry_out.smem;
    assign buf_ready       = entry_out.smem ? smem_req_ready : dmem_req_ready;

    assign smem_req_rw     = entry_out.req.rw;
    assign smem_req_byteen = entry_out.req.byteen;
    assign smem_req_addr   = entry_out.req.addr;
    assign smem_req_data   = entry_out.req.data;
    assign smem_req_tag    = entry_out.req.tag;

    assign dmem_req_rw     = entry_out.req.rw;
    assign dmem_req_byteen = entry_out.req.byteen;
    assign dmem_req_addr   = entry_out.req.addr;
    assign dmem_req_data   = entry_out.req.data;
    assign dmem_req_tag    = entry_out.req.tag;

    // Shared memory wins the response port
    assign data_rsp_valid = smem_rsp_valid || dmem_rsp_valid;
    assign data_rsp_data  = smem_rsp_valid ? smem_rsp_data : dmem_rsp_data;
    assign data_rsp_tag   = smem_rsp_valid ? {smem_rsp_tag, 1'b1} : {dmem_rsp_tag, 1'b0};
    assign smem_rsp_ready = data_rsp_ready;
    assign dmem_rsp_ready = data_rsp_ready && !smem_rsp_valid;

endmodule

//--- hdl/shared_mem.sv
`timescale 1ns/1ps

module shared_mem import mem_unit_pkg::*; #(
    parameter int SMEM_WORDS = 256
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      smem_req_valid,
    input  logic                      smem_req_rw,
    input  logic [BYTEEN_WIDTH-1:0]   smem_req_byteen,
    input  logic [ADDR_WIDTH-1:0]     smem_req_addr,
    input  logic [DATA_WIDTH-1:0]     smem_req_data,
    input  logic [SMEM_TAG_WIDTH-1:0] smem_req_tag,
    output logic                      smem_req_ready,

    output logic                      smem_rsp_valid,
    output logic [DATA_WIDTH-1:0]     smem_rsp_data,
    output logic [SMEM_TAG_WIDTH-1:0] smem_rsp_tag,
    input  logic                      smem_rsp_ready
);

    localparam int IDX_BITS = $clog2(SMEM_WORDS);

    logic [DATA_WIDTH-1:0] mem [SMEM_WORDS];
    data_req_t             req;
    logic [IDX_BITS-1:0]   idx;
    logic                  req_fire;

    assign req = {smem_req_addr, smem_req_rw, smem_req_byteen, smem_req_data, smem_req_tag};
    assign idx = req.addr[IDX_BITS-1:0];

    // Response register empty or draining this cycle
    assign smem_req_ready = !smem_rsp_valid || smem_rsp_ready;
    assign req_fire       = smem_req_valid && smem_req_ready;

    always_ff @(posedge clk) begin
        if (req_fire && req.rw) begin
            for (int i = 0; i < BYTEEN_WIDTH; i++) begin
                if (req.byteen[i]) begin
                    mem[idx][8*i +: 8] <= req.data[8*i +: 8];
                end
            end
        end
        if (req_fire && !req.rw) begin
            smem_rsp_data <= mem[idx];
            smem_rsp_tag  <= req.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            smem_rsp_valid <= 1'b0;
        end else if (req_fire && !req.rw) begin
            smem_rsp_valid <= 1'b1;
        end else if (smem_rsp_ready) begin
            smem_rsp_valid <= 1'b0;
        end
    end

endmodule

//--- hdl/mem_arb.sv
`timescale 1ns/1ps

module mem_arb import mem_unit_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       fetch_req_valid,
    input  logic [ADDR_WIDTH-1:0]      fetch_req_addr,
    input  logic [MEM_TAG_WIDTH-2:0]   fetch_req_tag,
    output logic                       fetch_req_ready,

    output logic                       fetch_rsp_valid,
    output logic [DATA_WIDTH-1:0]      fetch_rsp_data,
    output logic [MEM_TAG_WIDTH-2:0]   fetch_rsp_tag,
    input  logic                       fetch_rsp_ready,

    input  logic                       dmem_req_valid,
    input  logic                       dmem_req_rw,
    input  logic [BYTEEN_WIDTH-1:0]    dmem_req_byteen,
    input  logic [ADDR_WIDTH-1:0]      dmem_req_addr,
    input  logic [DATA_WIDTH-1:0]      dmem_req_data,
    input  logic [SMEM_TAG_WIDTH-1:0]  dmem_req_tag,
    output logic                       dmem_req_ready,

    output logic                       dmem_rsp_valid,
    output logic [DATA_WIDTH-1:0]      dmem_rsp_data,
    output logic [SMEM_TAG_WIDTH-1:0]  dmem_rsp_tag,
    input  logic                       dmem_rsp_ready,

    output logic                       mem_req_valid,
    output logic                       mem_req_rw,
    output logic [BYTEEN_WIDTH-1:0]    mem_req_byteen,
    output logic [ADDR_WIDTH-1:0]      mem_req_addr,
    output logic [DATA_WIDTH-1:0]      mem_req_data,
    output logic [MEM_TAG_WIDTH-1:0]   mem_req_tag,
    input  logic                       mem_req_ready,

    input  logic                       mem_rsp_valid,
    input  logic [DATA_WIDTH-1:0]      mem_rsp_data,
    input  logic [MEM_TAG_WIDTH-1:0]   mem_rsp_tag,
    output logic                       mem_rsp_ready
);

    logic     prio_data;
    logic     grant_data;
    logic     grant_fetch;
    logic     buf_ready;
    mem_req_t req_in;
    mem_req_t req_out;

    // Priority flips to the other source after each grant
    assign grant_data  = dmem_req_valid && (!fetch_req_valid || prio_data);
    assign grant_fetch = fetch_req_valid && !grant_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_data <= 1'b0;
        end else if (buf_ready && (grant_data || grant_fetch)) begin
            prio_data <= grant_fetch;
        end
    end

    assign fetch_req_ready = buf_ready && grant_fetch;
    assign dmem_req_ready  = buf_ready && grant_data;

    // Fetches are plain reads
    assign req_in = grant_data
        ? {dmem_req_addr, dmem_req_rw, dmem_req_byteen, dmem_req_data, dmem_req_tag, 1'b1}
        : {fetch_req_addr, 1'b0, {BYTEEN_WIDTH{1'b0}}, {DATA_WIDTH{1'b0}}, fetch_req_tag, 1'b0};

    skid_buffer #(
        .T (mem_req_t)
    ) req_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (fetch_req_valid || dmem_req_valid),
        .data_in   (req_in),
        .ready_in  (buf_ready),
        .valid_out (mem_req_valid),
        .data_out  (req_out),
        .ready_out (mem_req_ready)
    );

    assign mem_req_rw     = req_out.rw;
    assign mem_req_byteen = req_out.byteen;
    assign mem_req_addr   = req_out.addr;
    assign mem_req_data   = req_out.data;
    assign mem_req_tag    = req_out.tag;

    // Route responses by the source bit
    assign fetch_rsp_valid = mem_rsp_valid && !mem_rsp_tag[0];
    assign dmem_rsp_valid  = mem_rsp_valid && mem_rsp_tag[0];
    assign fetch_rsp_data  = mem_rsp_data;
    assign dmem_rsp_data   = mem_rsp_data;
    assign fetch_rsp_tag   = mem_rsp_tag[MEM_TAG_WIDTH-1:1];
    assign dmem_rsp_tag    = mem_rsp_tag[MEM_TAG_WIDTH-1:1];
    assign mem_rsp_ready   = mem_rsp_tag[0] ? dmem_rsp_ready : fetch_rsp_ready;

endmodule

//--- hdl/mem_perf.sv
`timescale 1ns/1ps

module mem_perf #(
    parameter int PERF_CTR_BITS = 32
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     mem_req_valid,
    input  logic                     mem_req_rw,
    input  logic                     mem_req_ready,
    input  logic                     mem_rsp_valid,
    input  logic                     mem_rsp_ready,
    output logic [PERF_CTR_BITS-1:0] perf_mem_reads,
    output logic [PERF_CTR_BITS-1:0] perf_mem_writes,
    output logic [PERF_CTR_BITS-1:0] perf_mem_latency
);

    logic [PERF_CTR_BITS-1:0] pending_reads;
    logic                     read_fire;
    logic                     write_fire;
    logic                     rsp_fire;

    assign read_fire  = mem_req_valid && mem_req_ready && !mem_req_rw;
    assign write_fire = mem_req_valid && mem_req_ready && mem_req_rw;
    assign rsp_fire   = mem_rsp_valid && mem_rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_reads    <= '0;
            perf_mem_reads   <= '0;
            perf_mem_writes  <= '0;
            perf_mem_latency <= '0;
        end else begin
            // Both at once leaves the count unchanged
            if (read_fire && !rsp_fire) begin
                pending_reads <= pending_reads + 1'b1;
            end else if (rsp_fire && !read_fire) begin
                pending_reads <= pending_reads - 1'b1;
            end
            if (read_fire) begin
                perf_mem_reads <= perf_mem_reads + 1'b1;
            end
            if (write_fire) begin
                perf_mem_writes <= perf_mem_writes + 1'b1;
            end
            perf_mem_latency <= perf_mem_latency + pending_reads;
        end
    end

endmodule

//--- hdl/mem_unit.sv
`timescale 1ns/1ps

module mem_unit import mem_unit_pkg::*; #(
    parameter int SMEM_WORDS    = 256,
    parameter int PERF_CTR_BITS = 32
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      fetch_req_valid,
    input  logic [ADDR_WIDTH-1:0]     fetch_req_addr,
    input  logic [MEM_TAG_WIDTH-2:0]  fetch_req_tag,
    output logic                      fetch_req_ready,
    output logic                      fetch_rsp_valid,
    output logic [DATA_WIDTH-1:0]     fetch_rsp_data,
    output logic [MEM_TAG_WIDTH-2:0]  fetch_rsp_tag,
    input  logic                      fetch_rsp_ready,

    input  logic                      data_req_valid,
    input  logic                      data_req_rw,
    input  logic [BYTEEN_WIDTH-1:0]   data_req_byteen,
    input  logic [ADDR_WIDTH-1:0]     data_req_addr,
    input  logic [DATA_WIDTH-1:0]     data_req_data,
    input  logic [CORE_TAG_WIDTH-1:0] data_req_tag,
    output logic                      data_req_ready,
    output logic                      data_rsp_valid,
    output logic [DATA_WIDTH-1:0]     data_rsp_data,
    output logic [CORE_TAG_WIDTH-1:0] data_rsp_tag,
    input  logic                      data_rsp_ready,

    output logic                      mem_req_valid,
    output logic                      mem_req_rw,
    output logic [BYTEEN_WIDTH-1:0]   mem_req_byteen,
    output logic [ADDR_WIDTH-1:0]     mem_req_addr,
    output logic [DATA_WIDTH-1:0]     mem_req_data,
    output logic [MEM_TAG_WIDTH-1:0]  mem_req_tag,
    input  logic                      mem_req_ready,
    input  logic                      mem_rsp_valid,
    input  logic [DATA_WIDTH-1:0]     mem_rsp_data,
    input  logic [MEM_TAG_WIDTH-1:0]  mem_rsp_tag,
    output logic                      mem_rsp_ready,

    output logic [PERF_CTR_BITS-1:0]  perf_mem_reads,
    output logic [PERF_CTR_BITS-1:0]  perf_mem_writes,
    output logic [PERF_CTR_BITS-1:0]  perf_mem_latency
);

    // Data port to scratchpad
    logic                      smem_req_valid;
    logic                      smem_req_rw;
    logic [BYTEEN_WIDTH-1:0]   smem_req_byteen;
    logic [ADDR_WIDTH-1:0]     smem_req_addr;
    logic [DATA_WIDTH-1:0]     smem_req_data;
    logic [SMEM_TAG_WIDTH-1:0] smem_req_tag;
    logic                      smem_req_ready;
    logic                      smem_rsp_valid;
    logic [DATA_WIDTH-1:0]     smem_rsp_data;
    logic [SMEM_TAG_WIDTH-1:0] smem_rsp_tag;
    logic                      smem_rsp_ready;

    // Data port to external arbiter
    logic                      dmem_req_valid;
    logic                      dmem_req_rw;
    logic [BYTEEN_WIDTH-1:0]   dmem_req_byteen;
    logic [ADDR_WIDTH-1:0]     dmem_req_addr;
    logic [DATA_WIDTH-1:0]     dmem_req_data;
    logic [SMEM_TAG_WIDTH-1:0] dmem_req_tag;
    logic                      dmem_req_ready;
    logic                      dmem_rsp_valid;
    logic [DATA_WIDTH-1:0]     dmem_rsp_data;
    logic [SMEM_TAG_WIDTH-1:0] dmem_rsp_tag;
    logic                      dmem_rsp_ready;

    smem_arb smem_arb_i (.*);

    shared_mem #(
        .SMEM_WORDS (SMEM_WORDS)
    ) smem (.*);

    mem_arb mem_arb_i (.*);

    mem_perf #(
        .PERF_CTR_BITS (PERF_CTR_BITS)
    ) perf (.*);

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

//--- bench/mem_model.sv
`timescale 1ns/1ps

module mem_model import mem_unit_pkg::*; #(
    parameter int LATENCY = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     mem_req_valid,
    input  logic                     mem_req_rw,
    input  logic [BYTEEN_WIDTH-1:0]  mem_req_byteen,
    input  logic [ADDR_WIDTH-1:0]    mem_req_addr,
    input  logic [DATA_WIDTH-1:0]    mem_req_data,
    input  logic [MEM_TAG_WIDTH-1:0] mem_req_tag,
    output logic                     mem_req_ready,
    output logic                     mem_rsp_valid,
    output logic [DATA_WIDTH-1:0]    mem_rsp_data,
    output logic [MEM_TAG_WIDTH-1:0] mem_rsp_tag,
    input  logic                     mem_rsp_ready
);

    logic [DATA_WIDTH-1:0]    words [logic [ADDR_WIDTH-1:0]];
    int                       due_q [$];
    logic [DATA_WIDTH-1:0]    data_q [$];
    logic [MEM_TAG_WIDTH-1:0] tag_q [$];
    logic [DATA_WIDTH-1:0]    word;
    int                       cycle;

    // Unwritten words read as a pattern of their address
    function automatic logic [DATA_WIDTH-1:0] read_word(input logic [ADDR_WIDTH-1:0] addr);
        if (words.exists(addr)) begin
            return words[addr];
        end
        return {2'b00, addr} ^ 32'h5a5a_0000;
    endfunction

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        mem_rsp_tag   = '0;
        cycle         = 0;
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycle++;
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(due_q.pop_front());
                void'(data_q.pop_front());
                void'(tag_q.pop_front());
            end
            if (mem_req_valid && mem_req_ready) begin
                word = read_word(mem_req_addr);
                if (mem_req_rw) begin
                    for (int i = 0; i < BYTEEN_WIDTH; i++) begin
                        if (mem_req_byteen[i]) begin
                            word[8*i +: 8] = mem_req_data[8*i +: 8];
                        end
                    end
                    words[mem_req_addr] = word;
                end else begin
                    due_q.push_back(cycle + LATENCY);
                    data_q.push_back(word);
                    tag_q.push_back(mem_req_tag);
                end
            end
            #1;
            mem_req_ready = 1'b1;
            // Oldest read shows up once its delay is over
            mem_rsp_valid = due_q.size() > 0 && due_q[0] <= cycle + 1;
            if (mem_rsp_valid) begin
                mem_rsp_data = data_q[0];
                mem_rsp_tag  = tag_q[0];
            end
        end
    end

endmodule

//--- bench/mem_unit_tb.sv
`timescale 1ns/1ps

module mem_unit_tb import mem_unit_pkg::*; ();

    localparam int   NUM_STEPS      = 31;
    localparam int   NUM_TESTS      = 6;
    localparam int   TIMEOUT_CYCLES = NUM_STEPS * 40 + 200;
    localparam logic FETCH = 1'b0;
    localparam logic DATA  = 1'b1;
    localparam logic RD    = 1'b0;
    localparam logic WR    = 1'b1;

    typedef struct {
        int                        test;
        logic                      data_port;
        logic                      rw;
        logic [ADDR_WIDTH-1:0]     addr;
        logic [BYTEEN_WIDTH-1:0]   byteen;
        logic [DATA_WIDTH-1:0]     wdata;
        logic [CORE_TAG_WIDTH-1:0] tag;
        logic [DATA_WIDTH-1:0]     rdata;
    } step_t;

    logic                      clk;
    logic                      reset;
    logic                      fetch_req_valid;
    logic [ADDR_WIDTH-1:0]     fetch_req_addr;
    logic [MEM_TAG_WIDTH-2:0]  fetch_req_tag;
    logic                      fetch_req_ready;
    logic                      fetch_rsp_valid;
    logic [DATA_WIDTH-1:0]     fetch_rsp_data;
    logic [MEM_TAG_WIDTH-2:0]  fetch_rsp_tag;
    logic                      fetch_rsp_ready;
    logic                      data_req_valid;
    logic                      data_req_rw;
    logic [BYTEEN_WIDTH-1:0]   data_req_byteen;
    logic [ADDR_WIDTH-1:0]     data_req_addr;
    logic [DATA_WIDTH-1:0]     data_req_data;
    logic [CORE_TAG_WIDTH-1:0] data_req_tag;
    logic                      data_req_ready;
    logic                      data_rsp_valid;
    logic [DATA_WIDTH-1:0]     data_rsp_data;
    logic [CORE_TAG_WIDTH-1:0] data_rsp_tag;
    logic                      data_rsp_ready;
    logic                      mem_req_valid;
    logic                      mem_req_rw;
    logic [BYTEEN_WIDTH-1:0]   mem_req_byteen;
    logic [ADDR_WIDTH-1:0]     mem_req_addr;
    logic [DATA_WIDTH-1:0]     mem_req_data;
    logic [MEM_TAG_WIDTH-1:0]  mem_req_tag;
    logic                      mem_req_ready;
    logic                      mem_rsp_valid;
    logic [DATA_WIDTH-1:0]     mem_rsp_data;
    logic [MEM_TAG_WIDTH-1:0]  mem_rsp_tag;
    logic                      mem_rsp_ready;
    logic [31:0]               perf_mem_reads;
    logic [31:0]               perf_mem_writes;
    logic [31:0]               perf_mem_latency;

    step_t steps [NUM_STEPS];
    int    fetch_drive_q [$];
    int    data_drive_q [$];
    int    fetch_exp_q [$];
    int    ext_exp_q [$];
    int    smem_exp_q [$];
    int    errors;
    int    cycles;
    int    seed;
    logic  stall_en;

    clock_gen clkgen (.clk(clk), .reset(reset));

    mem_unit #(
        .SMEM_WORDS    (256),
        .PERF_CTR_BITS (32)
    ) uut (.*);

    mem_model #(.LATENCY(4)) ext_mem (.*);

    // Expected read data follows the byte-enable merge over the default pattern
    task automatic load_table();
        steps[0]  = '{1, FETCH, RD, 30'h010, 4'h0, 32'h0, 4'h1, 32'h5a5a_0010};
        steps[1]  = '{1, FETCH, RD, 30'h024, 4'h0, 32'h0, 4'h2, 32'h5a5a_0024};
        steps[2]  = '{1, FETCH, RD, 30'h3ff, 4'h0, 32'h0, 4'h7, 32'h5a5a_03ff};
        steps[3]  = '{2, DATA,  WR, 30'h040, 4'h5, 32'h1122_3344, 4'h2, 32'h0};
        steps[4]  = '{2, DATA,  RD, 30'h040, 4'h0, 32'h0, 4'h4, 32'h5a22_0044};
        steps[5]  = '{2, DATA,  WR, 30'h041, 4'h8, 32'haabb_ccdd, 4'h6, 32'h0};
        steps[6]  = '{2, DATA,  RD, 30'h041, 4'h0, 32'h0, 4'h8, 32'haa5a_0041};
        steps[7]  = '{3, DATA,  WR, 30'h005, 4'hf, 32'hdead_beef, 4'h3, 32'h0};
        steps[8]  = '{3, DATA,  WR, 30'h005, 4'h2, 32'h0000_1200, 4'h5, 32'h0};
        steps[9]  = '{3, DATA,  RD, 30'h005, 4'h0, 32'h0, 4'h7, 32'hdead_12ef};
        steps[10] = '{3, DATA,  WR, 30'h006, 4'hf, 32'h0102_0304, 4'h9, 32'h0};
        steps[11] = '{3, DATA,  RD, 30'h006, 4'h0, 32'h0, 4'hb, 32'h0102_0304};
        steps[12] = '{4, FETCH, RD, 30'h100, 4'h0, 32'h0, 4'h0, 32'h5a5a_0100};
        steps[13] = '{4, DATA,  RD, 30'h040, 4'h0, 32'h0, 4'ha, 32'h5a22_0044};
        steps[14] = '{4, FETCH, RD, 30'h101, 4'h0, 32'h0, 4'h1, 32'h5a5a_0101};
        steps[15] = '{4, DATA,  RD, 30'h200, 4'h0, 32'h0, 4'hc, 32'h5a5a_0200};
        steps[16] = '{4, FETCH, RD, 30'h102, 4'h0, 32'h0, 4'h2, 32'h5a5a_0102};
        steps[17] = '{4, DATA,  RD, 30'h041, 4'h0, 32'h0, 4'he, 32'haa5a_0041};
        steps[18] = '{5, FETCH, RD, 30'h380, 4'h0, 32'h0, 4'h3, 32'h5a5a_0380};
        steps[19] = '{5, DATA,  WR, 30'h300, 4'h3, 32'h0000_beef, 4'h0, 32'h0};
        steps[20] = '{5, DATA,  RD, 30'h300, 4'h0, 32'h0, 4'h2, 32'h5a5a_beef};
        steps[21] = '{5, DATA,  RD, 30'h005, 4'h0, 32'h0, 4'hb, 32'hdead_12ef};
        steps[22] = '{5, FETCH, RD, 30'h381, 4'h0, 32'h0, 4'h4, 32'h5a5a_0381};
        steps[23] = '{5, DATA,  RD, 30'h006, 4'h0, 32'h0, 4'hd, 32'h0102_0304};
        steps[24] = '{5, FETCH, RD, 30'h382, 4'h0, 32'h0, 4'h5, 32'h5a5a_0382};
        steps[25] = '{5, DATA,  RD, 30'h201, 4'h0, 32'h0, 4'h4, 32'h5a5a_0201};
        steps[26] = '{5, FETCH, RD, 30'h383, 4'h0, 32'h0, 4'h6, 32'h5a5a_0383};
        steps[27] = '{5, DATA,  RD, 30'h300, 4'h0, 32'h0, 4'h6, 32'h5a5a_beef};
        steps[28] = '{6, DATA,  WR, 30'h050, 4'hf, 32'h0bad_f00d, 4'h0, 32'h0};
        steps[29] = '{6, DATA,  RD, 30'h050, 4'h0, 32'h0, 4'h2, 32'h0bad_f00d};
        steps[30] = '{6, FETCH, RD, 30'h060, 4'h0, 32'h0, 4'h0, 32'h5a5a_0060};
    endtask

    function automatic string describe(input int t);
        case (t)
            1: return "fetch reads of unwritten words";
            2: return "external data write then read";
            3: return "shared memory write then read";
            4: return "interleaved fetch and data reads";
            5: return "random response back-pressure";
            default: return "external port counters";
        endcase
    endfunction

    // External requests of one kind issued in tests up to last_test
    function automatic int ext_count(input int last_test, input logic rw);
        int n;
        n = 0;
        for (int i = 0; i < NUM_STEPS; i++) begin
            if (steps[i].test <= last_test && steps[i].rw == rw
                && (!steps[i].data_port || !steps[i].tag[0])) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic logic random_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic schedule_step(input int i);
        if (!steps[i].data_port) begin
            fetch_drive_q.push_back(i);
            fetch_exp_q.push_back(i);
        end else begin
            data_drive_q.push_back(i);
            if (!steps[i].rw && steps[i].tag[0]) begin
                smem_exp_q.push_back(i);
            end else if (!steps[i].rw) begin
                ext_exp_q.push_back(i);
            end
        end
    endtask

    // Wait for all requests and responses and let writes settle
    task automatic drain();
        while (fetch_drive_q.size() + data_drive_q.size() + fetch_exp_q.size()
               + ext_exp_q.size() + smem_exp_q.size() > 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (fetch_req_valid && fetch_req_ready) begin
                void'(fetch_drive_q.pop_front());
            end
            #1;
            fetch_req_valid = fetch_drive_q.size() > 0;
            if (fetch_req_valid) begin
                fetch_req_addr = steps[fetch_drive_q[0]].addr;
                fetch_req_tag  = steps[fetch_drive_q[0]].tag[2:0];
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            if (data_req_valid && data_req_ready) begin
                void'(data_drive_q.pop_front());
            end
            #1;
            data_req_valid = data_drive_q.size() > 0;
            if (data_req_valid) begin
                data_req_rw     = steps[data_drive_q[0]].rw;
                data_req_addr   = steps[data_drive_q[0]].addr;
                data_req_byteen = steps[data_drive_q[0]].byteen;
                data_req_data   = steps[data_drive_q[0]].wdata;
                data_req_tag    = steps[data_drive_q[0]].tag;
            end
        end
    end

    always @(posedge clk) begin
        #1;
        fetch_rsp_ready = stall_en ? random_bit() : 1'b1;
        data_rsp_ready  = stall_en ? random_bit() : 1'b1;
    end

    // Each port answers in its own request order
    always @(posedge clk) begin : rsp_monitor
        int idx;
        if (!reset && fetch_rsp_valid && fetch_rsp_ready) begin
            if (fetch_exp_q.size() == 0) begin
                $display("Fetch response with tag %h came with no read outstanding",
                         fetch_rsp_tag);
                errors++;
            end else begin
                idx = fetch_exp_q.pop_front();
                check_value("fetch_rsp_data", fetch_rsp_data, steps[idx].rdata);
                check_value("fetch_rsp_tag", 32'(fetch_rsp_tag), 32'(steps[idx].tag[2:0]));
            end
        end
        if (!reset && data_rsp_valid && data_rsp_ready) begin
            if (data_rsp_tag[0] ? smem_exp_q.size() == 0 : ext_exp_q.size() == 0) begin
                $display("Data response with tag %h came with no read outstanding",
                         data_rsp_tag);
                errors++;
            end else begin
                idx = data_rsp_tag[0] ? smem_exp_q.pop_front() : ext_exp_q.pop_front();
                check_value("data_rsp_data", data_rsp_data, steps[idx].rdata);
                check_value("data_rsp_tag", 32'(data_rsp_tag), 32'(steps[idx].tag));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with requests or responses outstanding",
                     cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin : sequencer
        int          err_start;
        int          failed;
        int          exp_reads;
        int          exp_writes;
        fetch_req_valid = 1'b0;
        fetch_req_addr  = '0;
        fetch_req_tag   = '0;
        fetch_rsp_ready = 1'b1;
        data_req_valid  = 1'b0;
        data_req_rw     = 1'b0;
        data_req_byteen = '0;
        data_req_addr   = '0;
        data_req_data   = '0;
        data_req_tag    = '0;
        data_rsp_ready  = 1'b1;
        stall_en        = 1'b0;
        errors          = 0;
        cycles          = 0;
        failed          = 0;
        seed            = 32'h4926_c513;
        load_table();
        wait (!reset);
        @(posedge clk);
        for (int t = 1; t <= NUM_TESTS; t++) begin
            err_start = errors;
            stall_en  = (t == 5);
            for (int i = 0; i < NUM_STEPS; i++) begin
                if (steps[i].test == t) begin
                    schedule_step(i);
                end
            end
            drain();
            // Scratchpad traffic stays off the external port
            if (t == 3) begin
                check_value("perf_mem_reads", perf_mem_reads, ext_count(t - 1, RD));
                check_value("perf_mem_writes", perf_mem_writes, ext_count(t - 1, WR));
            end
            if (t == NUM_TESTS) begin
                exp_reads  = ext_count(NUM_TESTS, RD);
                exp_writes = ext_count(NUM_TESTS, WR);
                check_value("perf_mem_reads", perf_mem_reads, exp_reads);
                check_value("perf_mem_writes", perf_mem_writes, exp_writes);
                assert (perf_mem_latency >= 32'(4 * exp_reads)) else begin
                    $display("ERR perf_mem_latency got %h expected at least %h",
                             perf_mem_latency, 32'(4 * exp_reads));
                    errors++;
                end
            end
            if (errors == err_start) begin
                $display("Test %0d (%s) passed", t, describe(t));
            end else begin
                failed++;
                $display("Test %0d (%s) failed with %0d errors", t, describe(t),
                         errors - err_start);
            end
        end
        $display("%0d of %0d tests passed, %0d check errors",
                 NUM_TESTS - failed, NUM_TESTS, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
hdl/mem_unit_pkg.sv
hdl/skid_buffer.sv
hdl/smem_arb.sv
hdl/shared_mem.sv
hdl/mem_arb.sv
hdl/mem_perf.sv
hdl/mem_unit.sv
bench/clock_gen.sv
bench/mem_model.sv
bench/mem_unit_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = mem_unit_tb
FILELIST  = project.f
BUILD     = obj_dir
LOG       = run.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
